// File: include/mrd_cfg.svh
`ifndef MRD_CFG_SVH
`define MRD_CFG_SVH

// Transform length, always a power of two
`define MRD_LOG2N 3
`define MRD_N (1 << `MRD_LOG2N)

// Signed input samples
`define MRD_IN_W 12

// Stored and output words
// Grows by log2 N bits over the stages, plus one guard bit
`define MRD_DATA_W (`MRD_IN_W + `MRD_LOG2N + 1)

// Twiddle components, signed Q1.14
`define MRD_TW_W 16

`endif

// File: verilog/mrd_pkg.sv
`default_nettype none

`include "mrd_cfg.svh"

package mrd_pkg;

	// Sample as it arrives at the frame port
	typedef logic signed [`MRD_IN_W-1:0] sample_t;
	// Word held in the banks and sent out
	typedef logic signed [`MRD_DATA_W-1:0] data_t;
	// Point address, natural or bit reversed
	typedef logic [`MRD_LOG2N-1:0] addr_t;
	// Address inside one bank, point address without bit 0
	typedef logic [`MRD_LOG2N-2:0] bank_addr_t;
	// Butterfly stage number
	typedef logic [1:0] stage_t;
	// One component of a twiddle factor
	typedef logic signed [`MRD_TW_W-1:0] twiddle_t;
	// Exponent k of W_N^k, range 0 to N/2-1
	typedef logic [`MRD_LOG2N-2:0] tw_idx_t;

	// Memory phases of one frame
	typedef enum logic [2:0]
	{
		idle,
		sink,
		rd,
		wait_wr_end,
		source
	} mem_state_t;

endpackage

`default_nettype wire

// File: verilog/mrd_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_bank_ram #(
	parameter int DEPTH = 4,
	parameter int WIDTH = 32
) (
	input logic clk,
	input logic wren,
	input mrd_pkg::bank_addr_t wraddr,
	input logic [WIDTH-1:0] din,
	input logic rden,
	input mrd_pkg::bank_addr_t rdaddr,
	output logic [WIDTH-1:0] dout
);

	// Real part in the upper half, imaginary in the lower half
	logic [WIDTH-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wren)
			mem[wraddr] <= din;
	end

	// Read port, registered
	// Holds its last word while rden is low
	always_ff @(posedge clk)
	begin
		if (rden)
			dout <= mem[rdaddr];
	end

endmodule

`default_nettype wire

// File: verilog/mrd_sink_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mrd_cfg.svh"

module mrd_sink_ctrl (
	input logic clk,
	input logic rst_n,
	input mrd_pkg::mem_state_t state,
	input logic in_valid,
	input mrd_pkg::sample_t in_real,
	input mrd_pkg::sample_t in_imag,
	output logic [1:0] wren,
	output mrd_pkg::bank_addr_t wraddr,
	output mrd_pkg::data_t wdata_real,
	output mrd_pkg::data_t wdata_imag,
	output logic sink_end
);

	localparam int EXT_W = `MRD_DATA_W - `MRD_IN_W;

	logic valid_r;
	mrd_pkg::sample_t real_r;
	mrd_pkg::sample_t imag_r;
	mrd_pkg::addr_t cnt;
	mrd_pkg::addr_t rev_addr;
	logic sink_wr;
	logic rev_bank;

	// Input register
	// The sample that came with in_sop is here on the first sink cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_r <= 1'b0;
		else
			valid_r <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		real_r <= in_real;
		imag_r <= in_imag;
	end

	assign sink_wr = (state == mrd_pkg::sink) && valid_r;

	// Valid samples seen in this frame
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (state != mrd_pkg::sink)
			cnt <= '0;
		else if (valid_r)
			cnt <= cnt + 1'b1;
	end

	// DIT needs the input in bit-reversed order
	always_comb
	begin
		for (int i = 0; i < `MRD_LOG2N; i++)
			rev_addr[i] = cnt[`MRD_LOG2N-1-i];
	end

	// Bank by parity, in-bank address drops bit 0
	assign rev_bank = ^rev_addr;
	assign wraddr = rev_addr[`MRD_LOG2N-1:1];
	assign wren[0] = sink_wr && !rev_bank;
	assign wren[1] = sink_wr && rev_bank;

	// Sign extension to the stored width
	assign wdata_real = {{EXT_W{real_r[`MRD_IN_W-1]}}, real_r};
	assign wdata_imag = {{EXT_W{imag_r[`MRD_IN_W-1]}}, imag_r};

	// Last sample of the frame
	assign sink_end = sink_wr && (cnt == mrd_pkg::addr_t'(`MRD_N - 1));

endmodule

`default_nettype wire

// File: verilog/mrd_stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mrd_cfg.svh"

module mrd_stage_ctrl (
	input logic clk,
	input logic rst_n,
	input mrd_pkg::mem_state_t state,
	output mrd_pkg::addr_t rd_addr_a,
	output mrd_pkg::addr_t rd_addr_b,
	output logic rden,
	output mrd_pkg::tw_idx_t tw_idx,
	output logic rd_end,
	input logic wb_valid,
	output logic wr_end,
	output logic last_stage
);

	// Pairs per stage
	localparam int NP = `MRD_N / 2;

	logic [`MRD_LOG2N-2:0] pair_cnt;
	logic [`MRD_LOG2N-2:0] wb_cnt;
	mrd_pkg::stage_t stage;
	mrd_pkg::addr_t span;
	mrd_pkg::addr_t offset;
	mrd_pkg::addr_t group;

	// ----------------------------------------
	// Operand addressing
	// ----------------------------------------

	// Distance between the two operands of a pair
	assign span = mrd_pkg::addr_t'(1) << stage;

	// Pair index split into offset in group and group bits
	assign offset = mrd_pkg::addr_t'(pair_cnt) & (span - 1'b1);
	assign group = mrd_pkg::addr_t'(pair_cnt) & ~(span - 1'b1);

	// Group base is the group bits moved up by one
	assign rd_addr_a = (group << 1) | offset;
	assign rd_addr_b = rd_addr_a | span;

	// k = offset * N / (2 * span)
	assign tw_idx = mrd_pkg::tw_idx_t'(offset << (`MRD_LOG2N - 1 - stage));

	// ----------------------------------------
	// Pair, write-back and stage counters
	// ----------------------------------------

	assign rden = (state == mrd_pkg::rd);
	assign rd_end = rden && (pair_cnt == NP - 1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pair_cnt <= '0;
		else if (!rden)
			pair_cnt <= '0;
		else
			pair_cnt <= pair_cnt + 1'b1;
	end

	// Results come back NP per stage, the counter wraps by itself
	assign wr_end = wb_valid && (wb_cnt == NP - 1);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wb_cnt <= '0;
		else if (state == mrd_pkg::idle)
			wb_cnt <= '0;
		else if (wb_valid)
			wb_cnt <= wb_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			stage <= '0;
		else if (state == mrd_pkg::idle)
			stage <= '0;
		else if (wr_end)
			stage <= stage + 1'b1;
	end

	assign last_stage = (stage == mrd_pkg::stage_t'(`MRD_LOG2N - 1));

endmodule

`default_nettype wire

// File: verilog/mrd_butterfly.sv
`timescale 1ns/1ps
`default_nettype none

`include "mrd_cfg.svh"

module mrd_butterfly (
	input logic clk,
	input logic rst_n,
	input logic bf_valid,
	input mrd_pkg::data_t bf_a_real,
	input mrd_pkg::data_t bf_a_imag,
	input mrd_pkg::data_t bf_b_real,
	input mrd_pkg::data_t bf_b_imag,
	input mrd_pkg::tw_idx_t bf_tw_idx,
	input mrd_pkg::addr_t bf_addr_a,
	input mrd_pkg::addr_t bf_addr_b,
	output logic wb_valid,
	output mrd_pkg::addr_t wb_addr_a,
	output mrd_pkg::addr_t wb_addr_b,
	output mrd_pkg::data_t wb_a_real,
	output mrd_pkg::data_t wb_a_imag,
	output mrd_pkg::data_t wb_b_real,
	output mrd_pkg::data_t wb_b_imag
);

	localparam int NH = `MRD_N / 2;
	localparam int TW_FRAC = `MRD_TW_W - 2;
	localparam int PROD_W = `MRD_DATA_W + `MRD_TW_W + 1;
	localparam real PI = 3.14159265358979323846;
	localparam real SCALE = 1.0 * (1 << TW_FRAC);
	// Half an LSB of the product, for round to nearest
	localparam logic signed [PROD_W-1:0] RND = 1 << (TW_FRAC - 1);

	mrd_pkg::twiddle_t rom_cos [NH];
	mrd_pkg::twiddle_t rom_sin [NH];

	logic s1_valid;
	mrd_pkg::data_t s1_a_re;
	mrd_pkg::data_t s1_a_im;
	mrd_pkg::data_t s1_b_re;
	mrd_pkg::data_t s1_b_im;
	mrd_pkg::twiddle_t s1_cos;
	mrd_pkg::twiddle_t s1_sin;
	mrd_pkg::addr_t s1_addr_a;
	mrd_pkg::addr_t s1_addr_b;

	logic signed [PROD_W-1:0] prod_re;
	logic signed [PROD_W-1:0] prod_im;

	logic s2_valid;
	mrd_pkg::data_t s2_a_re;
	mrd_pkg::data_t s2_a_im;
	mrd_pkg::data_t s2_bw_re;
	mrd_pkg::data_t s2_bw_im;
	mrd_pkg::addr_t s2_addr_a;
	mrd_pkg::addr_t s2_addr_b;

	// ----------------------------------------
	// Twiddle ROM, W_N^k = cos - j sin
	// ----------------------------------------
	for (genvar k = 0; k < NH; k++)
	begin : g_rom
		localparam real ANG = 2.0 * PI * k / `MRD_N;
		localparam int COS_V = $rtoi($floor(SCALE * $cos(ANG) + 0.5));
		localparam int SIN_V = $rtoi($floor(SCALE * $sin(ANG) + 0.5));

		assign rom_cos[k] = mrd_pkg::twiddle_t'(COS_V);
		assign rom_sin[k] = mrd_pkg::twiddle_t'(SIN_V);
	end

	// Valid travels with the data, addresses ride alongside
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			wb_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= bf_valid;
			s2_valid <= s1_valid;
			wb_valid <= s2_valid;
		end
	end

	// Stage 1, operands and ROM lookup
	always_ff @(posedge clk)
	begin
		s1_a_re <= bf_a_real;
		s1_a_im <= bf_a_imag;
		s1_b_re <= bf_b_real;
		s1_b_im <= bf_b_imag;
		s1_cos <= rom_cos[bf_tw_idx];
		s1_sin <= rom_sin[bf_tw_idx];
		s1_addr_a <= bf_addr_a;
		s1_addr_b <= bf_addr_b;
	end

	// b * W = (br*c + bi*s) + j(bi*c - br*s), rounded back to Q0
	assign prod_re = s1_b_re * s1_cos + s1_b_im * s1_sin + RND;
	assign prod_im = s1_b_im * s1_cos - s1_b_re * s1_sin + RND;

	// Stage 2, product
	always_ff @(posedge clk)
	begin
		s2_a_re <= s1_a_re;
		s2_a_im <= s1_a_im;
		s2_bw_re <= mrd_pkg::data_t'(prod_re >>> TW_FRAC);
		s2_bw_im <= mrd_pkg::data_t'(prod_im >>> TW_FRAC);
		s2_addr_a <= s1_addr_a;
		s2_addr_b <= s1_addr_b;
	end

	// Stage 3, sum and difference
	always_ff @(posedge clk)
	begin
		wb_a_real <= s2_a_re + s2_bw_re;
		wb_a_imag <= s2_a_im + s2_bw_im;
		wb_b_real <= s2_a_re - s2_bw_re;
		wb_b_imag <= s2_a_im - s2_bw_im;
		wb_addr_a <= s2_addr_a;
		wb_addr_b <= s2_addr_b;
	end

endmodule

`default_nettype wire

// File: verilog/mrd_source_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mrd_cfg.svh"

module mrd_source_ctrl (
	input logic clk,
	input logic rst_n,
	input mrd_pkg::mem_state_t state,
	output logic rden,
	output mrd_pkg::addr_t rd_addr,
	output logic rd_bank,
	output logic source_end,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop
);

	mrd_pkg::addr_t cnt;
	// Bit 0 after the RAM register, bit 1 after the output register
	logic [1:0] valid_d;
	logic [1:0] sop_d;
	logic [1:0] eop_d;
	logic bank_d;

	assign rden = (state == mrd_pkg::source);
	assign rd_addr = cnt;
	assign source_end = rden && (cnt == mrd_pkg::addr_t'(`MRD_N - 1));

	// Natural order bin counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (!rden)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Frame strobes, two cycles behind the read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid_d <= '0;
			sop_d <= '0;
			eop_d <= '0;
		end
		else
		begin
			valid_d <= {valid_d[0], rden};
			sop_d <= {sop_d[0], rden && (cnt == '0)};
			eop_d <= {eop_d[0], source_end};
		end
	end

	// Bank of the read, lined up with the RAM output
	// The output register in the memory top adds the second cycle
	always_ff @(posedge clk)
	begin
		bank_d <= ^cnt;
	end

	assign rd_bank = bank_d;
	assign out_valid = valid_d[1];
	assign out_sop = sop_d[1];
	assign out_eop = eop_d[1];

endmodule

`default_nettype wire

// File: verilog/mrd_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mrd_cfg.svh"

module mrd_mem_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_sop,
	input mrd_pkg::sample_t in_real,
	input mrd_pkg::sample_t in_imag,
	output logic bf_valid,
	output mrd_pkg::data_t bf_a_real,
	output mrd_pkg::data_t bf_a_imag,
	output mrd_pkg::data_t bf_b_real,
	output mrd_pkg::data_t bf_b_imag,
	output mrd_pkg::tw_idx_t bf_tw_idx,
	output mrd_pkg::addr_t bf_addr_a,
	output mrd_pkg::addr_t bf_addr_b,
	input logic wb_valid,
	input mrd_pkg::addr_t wb_addr_a,
	input mrd_pkg::addr_t wb_addr_b,
	input mrd_pkg::data_t wb_a_real,
	input mrd_pkg::data_t wb_a_imag,
	input mrd_pkg::data_t wb_b_real,
	input mrd_pkg::data_t wb_b_imag,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output mrd_pkg::data_t out_real,
	output mrd_pkg::data_t out_imag,
	output logic busy
);

	localparam int NB = 2;
	localparam int DEPTH = `MRD_N / 2;
	localparam int WORD_W = 2 * `MRD_DATA_W;

	mrd_pkg::mem_state_t state;
	logic frame_start;

	// Sink side
	logic [1:0] sink_wren;
	mrd_pkg::bank_addr_t sink_wraddr;
	mrd_pkg::data_t sink_real;
	mrd_pkg::data_t sink_imag;
	logic sink_end;

	// Stage reads and write-back
	mrd_pkg::addr_t st_addr_a;
	mrd_pkg::addr_t st_addr_b;
	logic st_rden;
	mrd_pkg::tw_idx_t st_tw_idx;
	logic rd_end;
	logic wr_end;
	logic last_stage;
	logic rd_bank_a;
	logic rd_bank_a_r;
	logic wb_bank_a;

	// Source side
	logic src_rden;
	mrd_pkg::addr_t src_addr;
	logic src_bank;
	logic source_end;

	logic [WORD_W-1:0] bank_dout [NB];

	// ----------------------------------------
	// Phase FSM
	// ----------------------------------------

	// in_sop counts only when the engine is free
	assign frame_start = (state == mrd_pkg::idle) && !busy && in_sop && in_valid;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= mrd_pkg::idle;
		else
		begin
			case (state)
				mrd_pkg::idle: if (frame_start) state <= mrd_pkg::sink;
				mrd_pkg::sink: if (sink_end) state <= mrd_pkg::rd;
				mrd_pkg::rd: if (rd_end) state <= mrd_pkg::wait_wr_end;
				mrd_pkg::wait_wr_end:
				begin
					// Stage counter still shows the stage just written
					if (wr_end && last_stage)
						state <= mrd_pkg::source;
					else if (wr_end)
						state <= mrd_pkg::rd;
				end
				mrd_pkg::source: if (source_end) state <= mrd_pkg::idle;
				default: state <= mrd_pkg::idle;
			endcase
		end
	end

	// High from the accepted in_sop until out_eop has gone out
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (frame_start)
			busy <= 1'b1;
		else if (out_eop)
			busy <= 1'b0;
	end

	// ----------------------------------------
	// Banks and port switches
	// ----------------------------------------

	// Pair members differ in one bit, so their parities differ
	assign wb_bank_a = ^wb_addr_a;
	assign rd_bank_a = ^st_addr_a;

	for (genvar i = 0; i < NB; i++)
	begin : g_bank
		logic wren;
		mrd_pkg::bank_addr_t wraddr;
		logic [WORD_W-1:0] din;
		logic rden;
		mrd_pkg::bank_addr_t rdaddr;
		logic own_a_wr;
		logic own_a_rd;

		assign own_a_wr = (wb_bank_a == 1'(i));
		assign own_a_rd = (rd_bank_a == 1'(i));

		// Write port, sink samples or butterfly results
		assign wren = (state == mrd_pkg::sink) ? sink_wren[i] : wb_valid;
		assign wraddr = (state == mrd_pkg::sink) ? sink_wraddr
			: own_a_wr ? wb_addr_a[`MRD_LOG2N-1:1] : wb_addr_b[`MRD_LOG2N-1:1];
		assign din = (state == mrd_pkg::sink) ? {sink_real, sink_imag}
			: own_a_wr ? {wb_a_real, wb_a_imag} : {wb_b_real, wb_b_imag};

		// Read port, operand pair or natural-order source
		assign rden = st_rden || src_rden;
		assign rdaddr = (state == mrd_pkg::rd)
			? (own_a_rd ? st_addr_a[`MRD_LOG2N-1:1] : st_addr_b[`MRD_LOG2N-1:1])
			: src_addr[`MRD_LOG2N-1:1];

		mrd_bank_ram #(
			.DEPTH(DEPTH),
			.WIDTH(WORD_W)
		) u_ram (
			.clk(clk),
			.wren(wren),
			.wraddr(wraddr),
			.din(din),
			.rden(rden),
			.rdaddr(rdaddr),
			.dout(bank_dout[i])
		);
	end

	// Operand strobe and side info, one cycle after the read
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bf_valid <= 1'b0;
		else
			bf_valid <= st_rden;
	end

	always_ff @(posedge clk)
	begin
		rd_bank_a_r <= rd_bank_a;
		bf_addr_a <= st_addr_a;
		bf_addr_b <= st_addr_b;
		bf_tw_idx <= st_tw_idx;
	end

	// Steer RAM data back to a and b
	assign {bf_a_real, bf_a_imag} = bank_dout[rd_bank_a_r];
	assign {bf_b_real, bf_b_imag} = bank_dout[~rd_bank_a_r];

	// Output word from the bank that the source read
	always_ff @(posedge clk)
	begin
		{out_real, out_imag} <= bank_dout[src_bank];
	end

	// ----------------------------------------
	// Controllers
	// ----------------------------------------
	mrd_sink_ctrl u_sink (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.in_valid(in_valid),
		.in_real(in_real),
		.in_imag(in_imag),
		.wren(sink_wren),
		.wraddr(sink_wraddr),
		.wdata_real(sink_real),
		.wdata_imag(sink_imag),
		.sink_end(sink_end)
	);

	mrd_stage_ctrl u_stage (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.rd_addr_a(st_addr_a),
		.rd_addr_b(st_addr_b),
		.rden(st_rden),
		.tw_idx(st_tw_idx),
		.rd_end(rd_end),
		.wb_valid(wb_valid),
		.wr_end(wr_end),
		.last_stage(last_stage)
	);

	mrd_source_ctrl u_source (
		.clk(clk),
		.rst_n(rst_n),
		.state(state),
		.rden(src_rden),
		.rd_addr(src_addr),
		.rd_bank(src_bank),
		.source_end(source_end),
		.out_valid(out_valid),
		.out_sop(out_sop),
		.out_eop(out_eop)
	);

endmodule

`default_nettype wire

// File: verilog/mrd_dft_top.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_dft_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_sop,
	input mrd_pkg::sample_t in_real,
	input mrd_pkg::sample_t in_imag,
	output logic out_valid,
	output logic out_sop,
	output logic out_eop,
	output mrd_pkg::data_t out_real,
	output mrd_pkg::data_t out_imag,
	output logic busy
);

	// Operands towards the butterfly
	logic bf_valid;
	mrd_pkg::data_t bf_a_real;
	mrd_pkg::data_t bf_a_imag;
	mrd_pkg::data_t bf_b_real;
	mrd_pkg::data_t bf_b_imag;
	mrd_pkg::tw_idx_t bf_tw_idx;
	mrd_pkg::addr_t bf_addr_a;
	mrd_pkg::addr_t bf_addr_b;

	// Results back to memory
	logic wb_valid;
	mrd_pkg::addr_t wb_addr_a;
	mrd_pkg::addr_t wb_addr_b;
	mrd_pkg::data_t wb_a_real;
	mrd_pkg::data_t wb_a_imag;
	mrd_pkg::data_t wb_b_real;
	mrd_pkg::data_t wb_b_imag;

	mrd_mem_top u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_sop(in_sop),
		.in_real(in_real),
		.in_imag(in_imag),
		.bf_valid(bf_valid),
		.bf_a_real(bf_a_real),
		.bf_a_imag(bf_a_imag),
		.bf_b_real(bf_b_real),
		.bf_b_imag(bf_b_imag),
		.bf_tw_idx(bf_tw_idx),
		.bf_addr_a(bf_addr_a),
		.bf_addr_b(bf_addr_b),
		.wb_valid(wb_valid),
		.wb_addr_a(wb_addr_a),
		.wb_addr_b(wb_addr_b),
		.wb_a_real(wb_a_real),
		.wb_a_imag(wb_a_imag),
		.wb_b_real(wb_b_real),
		.wb_b_imag(wb_b_imag),
		.out_valid(out_valid),
		.out_sop(out_sop),
		.out_eop(out_eop),
		.out_real(out_real),
		.out_imag(out_imag),
		.busy(busy)
	);

	mrd_butterfly u_bf (
		.clk(clk),
		.rst_n(rst_n),
		.bf_valid(bf_valid),
		.bf_a_real(bf_a_real),
		.bf_a_imag(bf_a_imag),
		.bf_b_real(bf_b_real),
		.bf_b_imag(bf_b_imag),
		.bf_tw_idx(bf_tw_idx),
		.bf_addr_a(bf_addr_a),
		.bf_addr_b(bf_addr_b),
		.wb_valid(wb_valid),
		.wb_addr_a(wb_addr_a),
		.wb_addr_b(wb_addr_b),
		.wb_a_real(wb_a_real),
		.wb_a_imag(wb_a_imag),
		.wb_b_real(wb_b_real),
		.wb_b_imag(wb_b_imag)
	);

endmodule

`default_nettype wire

// File: dv/mrd_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_clk_gen #(
	parameter real PERIOD = 8.0,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	// Free running clock
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Reset held low, released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/mrd_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mrd_chk (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_sop,
	input mrd_pkg::mem_state_t state,
	input logic wb_valid,
	input mrd_pkg::addr_t wb_addr_a,
	input mrd_pkg::addr_t wb_addr_b,
	input logic out_valid,
	input logic out_sop,
	input logic busy
);

	// Set by the first frame start seen after reset
	logic sop_seen;

	// Failed assertions so far
	int fail_count = 0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			sop_seen <= 1'b0;
		else if (in_sop && in_valid)
			sop_seen <= 1'b1;
	end

	// ----------------------------------------
	// Output frame strobes
	// ----------------------------------------
	a_sop_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_sop |-> out_valid)
		else
		begin
			$error("out_sop high without out_valid");
			fail_count++;
		end

	// Outputs start only while the source phase runs
	a_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> (state != mrd_pkg::idle))
		else
		begin
			$error("out_valid rose in the idle state");
			fail_count++;
		end

	// ----------------------------------------
	// Write-back and busy
	// ----------------------------------------

	// Pair members sit in banks of opposite parity
	a_wb_banks: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_valid && (state != mrd_pkg::sink)) |-> ((^wb_addr_a) != (^wb_addr_b)))
		else
		begin
			$error("write-back pair targets one bank twice");
			fail_count++;
		end

	a_busy_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!sop_seen |-> !busy)
		else
		begin
			$error("busy high before any frame was offered");
			fail_count++;
		end

endmodule

bind mrd_mem_top mrd_chk chk0 (
	.clk(clk),
	.rst_n(rst_n),
	.in_valid(in_valid),
	.in_sop(in_sop),
	.state(state),
	.wb_valid(wb_valid),
	.wb_addr_a(wb_addr_a),
	.wb_addr_b(wb_addr_b),
	.out_valid(out_valid),
	.out_sop(out_sop),
	.busy(busy)
);

`default_nettype wire

// File: dv/mrd_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mrd_cfg.svh"

module mrd_tb;

	localparam int N = `MRD_N;
	localparam int NT = 10;
	localparam int TOL = 2;
	localparam int QUIET = 12;
	localparam int FRAME_CYC = 4 * N * (`MRD_LOG2N + 2);
	localparam real PI = 3.14159265358979323846;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_sop;
	mrd_pkg::sample_t in_real;
	mrd_pkg::sample_t in_imag;
	logic out_valid;
	logic out_sop;
	logic out_eop;
	mrd_pkg::data_t out_real;
	mrd_pkg::data_t out_imag;
	logic busy;

	// Vector table with one array per field
	string tname [NT];
	int x_re [NT][N];
	int x_im [NT][N];
	logic [N-1:0] gaps [NT];
	bit intrude [NT];

	// Model bins of the current test
	int exp_re [N];
	int exp_im [N];

	// Outputs collected by the monitor
	int got_re [$];
	int got_im [$];
	bit got_sop [$];
	bit got_eop [$];

	int cur;
	int eop_seen;
	bit expect_busy;
	int test_errors;
	int total_errors;
	int clean_tests;

	mrd_clk_gen clk_gen0 (
		.clk(clk),
		.rst_n(rst_n)
	);

	mrd_dft_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_sop(in_sop),
		.in_real(in_real),
		.in_imag(in_imag),
		.out_valid(out_valid),
		.out_sop(out_sop),
		.out_eop(out_eop),
		.out_real(out_real),
		.out_imag(out_imag),
		.busy(busy)
	);

	// ----------------------------------------
	// Stimulus table and reference model
	// ----------------------------------------

	// Full-scale signed 12-bit value
	function automatic int rand_sample();
		return int'($urandom & 32'hfff) - 2048;
	endfunction

	function automatic int round_real(input real v);
		return $rtoi($floor(v + 0.5));
	endfunction

	function automatic void fill_table();
		for (int t = 0; t < NT; t++)
		begin
			gaps[t] = '0;
			intrude[t] = 1'b0;
			for (int n = 0; n < N; n++)
			begin
				x_re[t][n] = 0;
				x_im[t][n] = 0;
			end
		end
		tname[0] = "impulse";
		x_re[0][0] = 1000;
		tname[1] = "impulse_cplx";
		x_re[1][0] = -2048;
		x_im[1][0] = 777;
		tname[2] = "constant";
		tname[3] = "alternating";
		tname[4] = "constant_min";
		for (int n = 0; n < N; n++)
		begin
			x_re[2][n] = 300;
			x_re[3][n] = (n % 2 == 0) ? 500 : -500;
			x_re[4][n] = -2048;
			x_im[4][n] = -2048;
		end
		// Gaps on a known answer too
		gaps[2] = 8'b0001_0010;
		tname[5] = "random_a";
		tname[6] = "random_gaps";
		tname[7] = "random_intrude";
		tname[8] = "gaps_intrude";
		tname[9] = "random_b";
		for (int t = 5; t < NT; t++)
		begin
			for (int n = 0; n < N; n++)
			begin
				x_re[t][n] = rand_sample();
				x_im[t][n] = rand_sample();
			end
		end
		gaps[6] = 8'b1010_0110;
		intrude[7] = 1'b1;
		gaps[8] = 8'b1111_1110;
		intrude[8] = 1'b1;
	endfunction

	// X[k] = sum x[n] (cos - j sin) of 2 pi k n / N
	function automatic void compute_model(input int t);
		real acc_re;
		real acc_im;
		real ang;
		for (int k = 0; k < N; k++)
		begin
			acc_re = 0.0;
			acc_im = 0.0;
			for (int n = 0; n < N; n++)
			begin
				ang = 2.0 * PI * real'(k * n) / real'(N);
				acc_re += x_re[t][n] * $cos(ang) + x_im[t][n] * $sin(ang);
				acc_im += x_im[t][n] * $cos(ang) - x_re[t][n] * $sin(ang);
			end
			exp_re[k] = round_real(acc_re);
			exp_im[k] = round_real(acc_im);
		end
	endfunction

	// ----------------------------------------
	// Drivers
	// ----------------------------------------

	// Sample 0 rides with in_sop
	// Gap bit k idles one cycle before sample k
	task automatic drive_frame(input int t);
		in_sop = 1'b1;
		in_valid = 1'b1;
		in_real = mrd_pkg::sample_t'(x_re[t][0]);
		in_imag = mrd_pkg::sample_t'(x_im[t][0]);
		@(posedge clk);
		#1;
		in_sop = 1'b0;
		expect_busy = 1'b1;
		for (int k = 1; k < N; k++)
		begin
			if (gaps[t][k])
			begin
				in_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			in_valid = 1'b1;
			in_real = mrd_pkg::sample_t'(x_re[t][k]);
			in_imag = mrd_pkg::sample_t'(x_im[t][k]);
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
	endtask

	// A second frame offered during the stage phases
	task automatic intrude_frame();
		repeat (3) @(posedge clk);
		#1;
		in_sop = 1'b1;
		for (int k = 0; k < N; k++)
		begin
			in_valid = 1'b1;
			in_real = mrd_pkg::sample_t'(rand_sample());
			in_imag = mrd_pkg::sample_t'(rand_sample());
			@(posedge clk);
			#1;
			in_sop = 1'b0;
		end
		in_valid = 1'b0;
	endtask

	// ----------------------------------------
	// Monitor sampling mid-cycle
	// ----------------------------------------
	always @(negedge clk)
	begin
		if (out_valid)
		begin
			got_re.push_back(int'(out_real));
			got_im.push_back(int'(out_imag));
			got_sop.push_back(out_sop);
			got_eop.push_back(out_eop);
		end
		if (expect_busy)
			assert (busy)
			else
			begin
				$display("Busy dropped before out_eop in test %s", tname[cur]);
				test_errors++;
			end
		if (out_valid && out_eop)
		begin
			eop_seen++;
			expect_busy = 1'b0;
		end
	end

	// ----------------------------------------
	// Checks and test sequence
	// ----------------------------------------
	task automatic check_frame(input int t);
		int dre;
		int dim;
		assert (got_re.size() == N)
		else
		begin
			$display("Fail %s output count: expected %0d actual %0d",
				tname[t], N, got_re.size());
			test_errors++;
		end
		for (int k = 0; k < N && k < got_re.size(); k++)
		begin
			dre = exp_re[k] - got_re[k];
			dim = exp_im[k] - got_im[k];
			assert (dre <= TOL && dre >= -TOL)
			else
			begin
				$display("Fail %s bin %0d real: expected %0d actual %0d",
					tname[t], k, exp_re[k], got_re[k]);
				test_errors++;
			end
			assert (dim <= TOL && dim >= -TOL)
			else
			begin
				$display("Fail %s bin %0d imag: expected %0d actual %0d",
					tname[t], k, exp_im[k], got_im[k]);
				test_errors++;
			end
			assert (got_sop[k] == (k == 0) && got_eop[k] == (k == N - 1))
			else
			begin
				$display("Fail %s output %0d sop/eop: expected %0b/%0b actual %0b/%0b",
					tname[t], k, k == 0, k == N - 1, got_sop[k], got_eop[k]);
				test_errors++;
			end
		end
	endtask

	task automatic run_test(input int t);
		int start_eop;
		int waited;
		cur = t;
		test_errors = 0;
		got_re.delete();
		got_im.delete();
		got_sop.delete();
		got_eop.delete();
		compute_model(t);
		start_eop = eop_seen;
		drive_frame(t);
		if (intrude[t])
			intrude_frame();
		waited = 0;
		while (eop_seen == start_eop && waited < FRAME_CYC)
		begin
			@(posedge clk);
			waited++;
		end
		assert (eop_seen != start_eop)
		else
		begin
			$display("Test %s saw no out_eop within %0d cycles", tname[t], FRAME_CYC);
			test_errors++;
		end
		// A second frame would show up in this quiet window
		repeat (QUIET) @(posedge clk);
		#1;
		check_frame(t);
		assert (!busy)
		else
		begin
			$display("Test %s left busy high after its frame", tname[t]);
			test_errors++;
		end
		if (test_errors == 0)
		begin
			clean_tests++;
			$display("Test %s ok", tname[t]);
		end
		else
			$display("Test %s had %0d errors", tname[t], test_errors);
		total_errors += test_errors;
	endtask

	initial
	begin
		int chk_fails;
		// Seed before the first draw
		void'($urandom(24012));
		in_valid = 1'b0;
		in_sop = 1'b0;
		in_real = '0;
		in_imag = '0;
		cur = 0;
		eop_seen = 0;
		expect_busy = 1'b0;
		test_errors = 0;
		total_errors = 0;
		clean_tests = 0;
		fill_table();
		@(posedge rst_n);
		@(posedge clk);
		#1;
		for (int t = 0; t < NT; t++)
			run_test(t);
		// Assertions of the bound checker count as errors too
		chk_fails = dut0.u_mem.chk0.fail_count;
		if (chk_fails != 0)
		begin
			$display("Bound checker saw %0d assertion failures", chk_fails);
			total_errors += chk_fails;
		end
		$display("Summary: %0d of %0d tests clean, %0d check errors",
			clean_tests, NT, total_errors);
		if (total_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Watchdog budget per entry plus the reset time
	initial
	begin
		#((16 + NT * FRAME_CYC) * 8);
		$display("Watchdog expired before the test sequence completed");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
verilog/mrd_pkg.sv
verilog/mrd_bank_ram.sv
verilog/mrd_sink_ctrl.sv
verilog/mrd_stage_ctrl.sv
verilog/mrd_butterfly.sv
verilog/mrd_source_ctrl.sv
verilog/mrd_mem_top.sv
verilog/mrd_dft_top.sv
dv/mrd_clk_gen.sv
dv/mrd_chk.sv
dv/mrd_tb.sv

// File: Bender.yml
package:
  name: mrd_dft

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/mrd_pkg.sv
      - verilog/mrd_bank_ram.sv
      - verilog/mrd_sink_ctrl.sv
      - verilog/mrd_stage_ctrl.sv
      - verilog/mrd_butterfly.sv
      - verilog/mrd_source_ctrl.sv
      - verilog/mrd_mem_top.sv
      - verilog/mrd_dft_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/mrd_clk_gen.sv
      - dv/mrd_chk.sv
      - dv/mrd_tb.sv
